//--- cpu_consts.svh
// memory is 2**MEM_AW bytes and only the low pointer bits address it
// bank codes are register selector high nibbles, resolved through rfp
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// transfer memory address width
`define MEM_AW 8

// selector nibble for the bank that rfp points at
`define CUR_BANK 4'he

// selector nibble for bank rfp-1, wrapping over four banks
`define PREV_BANK 4'hd

// dump address that returns rfp
`define DUMP_RFP 8'h50

// stack pointer value after reset
`define XSP_INIT 32'h100

`endif

//--- cpu_pkg.sv
// types shared by the register file, the block-move engine and the memory
// mem_addr_t follows MEM_AW from the constants header
`include "cpu_consts.svh"

package cpu_pkg;

    // register selector, high nibble picks bank or pointer group
    typedef logic [7:0] reg_code_t;

    // register file pointer
    typedef logic [1:0] bank_ptr_t;

    // full register value
    typedef logic [31:0] reg_data_t;

    typedef logic [7:0] byte_t;

    typedef logic [`MEM_AW-1:0] mem_addr_t;

    // BC counter value
    typedef logic [15:0] count_t;

    typedef enum logic [1:0] {ws_byte, ws_word, ws_long} wsize_e;

    // block-move sequencing
    typedef enum logic [2:0] {
        st_idle,
        st_rd_req,
        st_rd_wait,
        st_wr,
        st_next
    } xfer_state_e;

endpackage

//--- reg_bank.sv
// rd_data: bits 7:0 are the selected byte, 15:8 the odd byte of its pair,
// 31:16 the upper word of its aligned long. High nibble 4 reads as zero.
// Transfer steps are one byte; host writes are not expected during a step.
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_bank
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  logic      inc_rfp,
    input  logic      dec_rfp,
    input  logic      rfp_we,
    input  bank_ptr_t rfp_imm,
    input  logic      reg_we,
    input  reg_code_t reg_sel,
    input  wsize_e    reg_size,
    input  reg_data_t reg_din,
    input  reg_code_t rd_sel,
    output reg_data_t rd_data,
    input  logic      step,
    input  logic      dir,
    output reg_data_t xix,
    output reg_data_t xde,
    output logic      bc_unity,
    input  byte_t     dmp_addr,
    output byte_t     dmp_dout
);

    localparam reg_data_t XSP_RESET = `XSP_INIT;

    // 0..63 are the four banks, 64..79 the pointer bytes
    byte_t      regs [80];
    bank_ptr_t  rfp;
    logic [6:0] wr_idx;
    logic [6:0] rd_idx;
    logic [6:0] xde_base;
    logic [6:0] bc_lo;
    logic [6:0] bc_hi;
    count_t     cur_bc;
    reg_data_t  xix_next;
    reg_data_t  xde_next;
    count_t     bc_next;

    // map a selector to a byte index, bank codes resolved through rfp
    function automatic logic [6:0] reg_index(input bank_ptr_t bank, input reg_code_t code);
        logic [3:0] grp;
        grp = code[7:4];
        if (grp == `CUR_BANK) begin
            grp = {2'b00, bank};
        end else if (grp == `PREV_BANK) begin
            grp = {2'b00, bank - 2'd1};
        end
        if (grp[3]) begin
            return {3'b100, code[3:0]};
        end
        return {1'b0, grp[1:0], code[3:0]};
    endfunction

    assign wr_idx = reg_index(rfp, reg_sel);
    assign rd_idx = reg_index(rfp, rd_sel);

    always_comb begin
        if (rd_sel[7:4] == 4'h4) begin
            rd_data = '0;
        end else begin
            rd_data = {regs[{rd_idx[6:2], 2'd3}], regs[{rd_idx[6:2], 2'd2}],
                       regs[{rd_idx[6:1], 1'b1}], regs[rd_idx]};
        end
    end

    // transfer registers of the current bank
    assign xde_base = {1'b0, rfp, 4'h8};
    assign bc_lo    = {1'b0, rfp, 4'h4};
    assign bc_hi    = {1'b0, rfp, 4'h5};

    assign xix    = {regs[67], regs[66], regs[65], regs[64]};
    assign xde    = {regs[{xde_base[6:2], 2'd3}], regs[{xde_base[6:2], 2'd2}],
                     regs[{xde_base[6:2], 2'd1}], regs[xde_base]};
    assign cur_bc = {regs[bc_hi], regs[bc_lo]};

    // dir high walks both pointers down
    assign xix_next = dir ? xix - 32'd1 : xix + 32'd1;
    assign xde_next = dir ? xde - 32'd1 : xde + 32'd1;
    assign bc_next  = cur_bc - 16'd1;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 80; i++) begin
                regs[i] <= '0;
            end
            // XSP is pointer bytes 12..15
            for (int i = 0; i < 4; i++) begin
                regs[{5'b10011, 2'(i)}] <= XSP_RESET[8*i +: 8];
            end
            bc_unity <= 1'b0;
        end else if (cen) begin
            // sampled before the step so the controller sees BC prior to decrement
            bc_unity <= cur_bc == 16'd1;
            if (step) begin
                for (int i = 0; i < 4; i++) begin
                    regs[{5'b10000, 2'(i)}]     <= xix_next[8*i +: 8];
                    regs[{xde_base[6:2], 2'(i)}] <= xde_next[8*i +: 8];
                end
                regs[bc_lo] <= bc_next[7:0];
                regs[bc_hi] <= bc_next[15:8];
            end
            // low byte of the value lands at the lowest index
            if (reg_we && reg_sel[7:4] != 4'h4) begin
                case (reg_size)
                    ws_byte: begin
                        regs[wr_idx] <= reg_din[7:0];
                    end
                    ws_word: begin
                        regs[{wr_idx[6:1], 1'b0}] <= reg_din[7:0];
                        regs[{wr_idx[6:1], 1'b1}] <= reg_din[15:8];
                    end
                    default: begin
                        for (int i = 0; i < 4; i++) begin
                            regs[{wr_idx[6:2], 2'(i)}] <= reg_din[8*i +: 8];
                        end
                    end
                endcase
            end
        end
    end

    // rfp_we over dec_rfp over inc_rfp
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rfp <= '0;
        end else if (cen) begin
            if (rfp_we) begin
                rfp <= rfp_imm;
            end else if (dec_rfp) begin
                rfp <= rfp - 2'd1;
            end else if (inc_rfp) begin
                rfp <= rfp + 2'd1;
            end
        end
    end

    // pointer bytes follow the banks, so 0x40+n is index 64+n
    always_ff @(posedge clk) begin
        if (cen) begin
            if (dmp_addr < 8'h50) begin
                dmp_dout <= regs[dmp_addr[6:0]];
            end else if (dmp_addr == `DUMP_RFP) begin
                dmp_dout <= {6'd0, rfp};
            end else begin
                dmp_dout <= '0;
            end
        end
    end

endmodule

//--- xfer_ctrl.sv
// one byte takes mem_wait+4 cycles: read request, wait, write, step
// start is taken only while idle; done pulses as busy drops
`timescale 1ns/1ps

module xfer_ctrl
    import cpu_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  logic start,
    input  logic dir_in,
    input  logic rpt,
    input  logic ready,
    input  logic bc_unity,
    output logic busy,
    output logic done,
    output logic load,
    output logic mem_we,
    output logic sel_dst,
    output logic step,
    output logic dir
);

    xfer_state_e state;
    logic        dir_q;
    logic        rpt_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= st_idle;
            dir_q <= 1'b0;
            rpt_q <= 1'b0;
            done  <= 1'b0;
        end else if (cen) begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        dir_q <= dir_in;
                        rpt_q <= rpt;
                        state <= st_rd_req;
                    end
                end
                // source address is on the memory, timer loaded
                st_rd_req: begin
                    state <= st_rd_wait;
                end
                st_rd_wait: begin
                    if (ready) begin
                        state <= st_wr;
                    end
                end
                // registered read data goes back in at XDE
                st_wr: begin
                    state <= st_next;
                end
                // bc_unity still reflects BC before this step
                st_next: begin
                    if (rpt_q && !bc_unity) begin
                        state <= st_rd_req;
                    end else begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign busy    = state != st_idle;
    assign load    = state == st_rd_req;
    assign mem_we  = state == st_wr;
    // destination pointer only while writing
    assign sel_dst = state == st_wr;
    assign step    = state == st_next;
    assign dir     = dir_q;

endmodule

//--- wait_timer.sv
// ready pulses one cycle, exactly wait_cnt+1 cycles after load
// a new load restarts the count
`timescale 1ns/1ps

module wait_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       load,
    input  logic [1:0] wait_cnt,
    output logic       ready
);

    logic [1:0] cnt;
    logic       armed;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            armed <= 1'b0;
            ready <= 1'b0;
        end else if (cen) begin
            ready <= 1'b0;
            if (load) begin
                // zero wait states answer on the next cycle
                if (wait_cnt == 2'd0) begin
                    ready <= 1'b1;
                    armed <= 1'b0;
                end else begin
                    cnt   <= wait_cnt - 2'd1;
                    armed <= 1'b1;
                end
            end else if (armed) begin
                if (cnt == 2'd0) begin
                    ready <= 1'b1;
                    armed <= 1'b0;
                end else begin
                    cnt <= cnt - 2'd1;
                end
            end
        end
    end

endmodule

//--- byte_ram.sv
// host port owns the memory while busy is low, transfer port while high
// reads are registered; contents are undefined until written
`timescale 1ns/1ps
`include "cpu_consts.svh"

module byte_ram
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      busy,
    input  logic      host_we,
    input  mem_addr_t host_addr,
    input  byte_t     host_din,
    output byte_t     host_dout,
    input  logic      xfer_we,
    input  mem_addr_t src_addr,
    input  mem_addr_t dst_addr,
    input  logic      sel_dst
);

    byte_t     mem [2**`MEM_AW];
    mem_addr_t xfer_addr;
    mem_addr_t rd_addr;
    byte_t     rd_q;

    // XIX while reading, XDE while writing
    assign xfer_addr = sel_dst ? dst_addr : src_addr;
    assign rd_addr   = busy ? xfer_addr : host_addr;
    assign host_dout = rd_q;

    always_ff @(posedge clk) begin
        if (busy) begin
            // moved byte is the last registered read
            if (xfer_we) begin
                mem[xfer_addr] <= rd_q;
            end
        end else if (host_we) begin
            mem[host_addr] <= host_din;
        end
        rd_q <= mem[rd_addr];
    end

endmodule

//--- xfer_top.sv
// banked register file plus block-move engine over a 2**MEM_AW byte memory
// host must not write registers or memory while busy is high
`timescale 1ns/1ps
`include "cpu_consts.svh"

module xfer_top
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       inc_rfp,
    input  logic       dec_rfp,
    input  logic       rfp_we,
    input  bank_ptr_t  rfp_imm,
    input  logic       reg_we,
    input  reg_code_t  reg_sel,
    input  wsize_e     reg_size,
    input  reg_data_t  reg_din,
    input  reg_code_t  rd_sel,
    output reg_data_t  rd_data,
    input  byte_t      dmp_addr,
    output byte_t      dmp_dout,
    input  logic       host_we,
    input  mem_addr_t  host_addr,
    input  byte_t      host_din,
    output byte_t      host_dout,
    input  logic       start,
    input  logic       dir,
    input  logic       rpt,
    input  logic [1:0] mem_wait,
    output logic       busy,
    output logic       done
);

    reg_data_t xix;
    reg_data_t xde;
    logic      bc_unity;
    logic      ready;
    logic      load;
    logic      mem_we;
    logic      sel_dst;
    logic      step;
    logic      xfer_dir;

    reg_bank reg_bank_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .inc_rfp  (inc_rfp),
        .dec_rfp  (dec_rfp),
        .rfp_we   (rfp_we),
        .rfp_imm  (rfp_imm),
        .reg_we   (reg_we),
        .reg_sel  (reg_sel),
        .reg_size (reg_size),
        .reg_din  (reg_din),
        .rd_sel   (rd_sel),
        .rd_data  (rd_data),
        .step     (step),
        .dir      (xfer_dir),
        .xix      (xix),
        .xde      (xde),
        .bc_unity (bc_unity),
        .dmp_addr (dmp_addr),
        .dmp_dout (dmp_dout)
    );

    xfer_ctrl xfer_ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .start    (start),
        .dir_in   (dir),
        .rpt      (rpt),
        .ready    (ready),
        .bc_unity (bc_unity),
        .busy     (busy),
        .done     (done),
        .load     (load),
        .mem_we   (mem_we),
        .sel_dst  (sel_dst),
        .step     (step),
        .dir      (xfer_dir)
    );

    wait_timer wait_timer_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .load     (load),
        .wait_cnt (mem_wait),
        .ready    (ready)
    );

    // pointers wrap inside the small memory
    byte_ram byte_ram_i (
        .clk       (clk),
        .busy      (busy),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_din  (host_din),
        .host_dout (host_dout),
        .xfer_we   (mem_we),
        .src_addr  (xix[`MEM_AW-1:0]),
        .dst_addr  (xde[`MEM_AW-1:0]),
        .sel_dst   (sel_dst)
    );

endmodule

//--- tb_xfer.sv
// random register, bank pointer and block-move checks against a byte-level model
// memory is filled with random bytes before the first move
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_xfer
    import cpu_pkg::*;
();

    localparam int        MOVE_LIMIT = 200;
    localparam reg_data_t XSP_VALUE  = `XSP_INIT;

    logic       clk;
    logic       rst;
    logic       cen;
    logic       inc_rfp;
    logic       dec_rfp;
    logic       rfp_we;
    bank_ptr_t  rfp_imm;
    logic       reg_we;
    reg_code_t  reg_sel;
    wsize_e     reg_size;
    reg_data_t  reg_din;
    reg_code_t  rd_sel;
    reg_data_t  rd_data;
    byte_t      dmp_addr;
    byte_t      dmp_dout;
    logic       host_we;
    mem_addr_t  host_addr;
    byte_t      host_din;
    byte_t      host_dout;
    logic       start;
    logic       dir;
    logic       rpt;
    logic [1:0] mem_wait;
    logic       busy;
    logic       done;

    // model: 64 bank bytes then 16 pointer bytes
    byte_t       m_regs [80];
    bank_ptr_t   m_rfp;
    byte_t       m_mem [2**`MEM_AW];
    logic [15:0] lfsr;

    xfer_top xfer_top_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .inc_rfp   (inc_rfp),
        .dec_rfp   (dec_rfp),
        .rfp_we    (rfp_we),
        .rfp_imm   (rfp_imm),
        .reg_we    (reg_we),
        .reg_sel   (reg_sel),
        .reg_size  (reg_size),
        .reg_din   (reg_din),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .dmp_addr  (dmp_addr),
        .dmp_dout  (dmp_dout),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_din  (host_din),
        .host_dout (host_dout),
        .start     (start),
        .dir       (dir),
        .rpt       (rpt),
        .mem_wait  (mem_wait),
        .busy      (busy),
        .done      (done)
    );

    always #10 clk = ~clk;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic wsize_e rand_size();
        logic [31:0] pick;
        pick = rand_bits(2) % 3;
        if (pick == 0) begin
            return ws_byte;
        end
        return (pick == 1) ? ws_word : ws_long;
    endfunction

    // banks 0..3, pointer group 8, or the zero group 4
    function automatic reg_code_t rand_abs_code();
        logic [31:0] pick;
        logic [3:0]  grp;
        pick = rand_bits(3) % 6;
        if (pick < 4) begin
            grp = pick[3:0];
        end else begin
            grp = (pick == 4) ? 4'h8 : 4'h4;
        end
        return {grp, 4'(rand_bits(4))};
    endfunction

    function automatic int model_index(input reg_code_t code);
        bank_ptr_t bank;
        if (code[7:4] == 4'h8) begin
            return 64 + int'(code[3:0]);
        end
        bank = code[5:4];
        if (code[7:4] == `CUR_BANK) begin
            bank = m_rfp;
        end else if (code[7:4] == `PREV_BANK) begin
            bank = m_rfp - 2'd1;
        end
        return 16 * int'(bank) + int'(code[3:0]);
    endfunction

    function automatic void model_write(input reg_code_t code, input wsize_e size,
                                        input reg_data_t data);
        int idx;
        idx = model_index(code);
        if (code[7:4] == 4'h4) begin
            return;
        end
        case (size)
            ws_byte: m_regs[idx] = data[7:0];
            ws_word: begin
                for (int k = 0; k < 2; k++) begin
                    m_regs[(idx & ~1) + k] = data[8*k +: 8];
                end
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    m_regs[(idx & ~3) + k] = data[8*k +: 8];
                end
            end
        endcase
    endfunction

    // selected byte, odd byte of its pair, upper word of its long
    function automatic reg_data_t model_read(input reg_code_t code);
        int idx;
        idx = model_index(code);
        if (code[7:4] == 4'h4) begin
            return '0;
        end
        return {m_regs[(idx & ~3) + 3], m_regs[(idx & ~3) + 2], m_regs[idx | 1], m_regs[idx]};
    endfunction

    function automatic byte_t model_dump(input byte_t addr);
        if (addr < 8'h50) begin
            return m_regs[addr];
        end
        return (addr == `DUMP_RFP) ? {6'd0, m_rfp} : 8'h00;
    endfunction

    task automatic stop_failed();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_bank(input bank_ptr_t got, input bank_ptr_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic write_reg(input reg_code_t code, input wsize_e size, input reg_data_t data);
        @(posedge clk);
        reg_we   <= 1'b1;
        reg_sel  <= code;
        reg_size <= size;
        reg_din  <= data;
        @(posedge clk);
        reg_we <= 1'b0;
        model_write(code, size, data);
    endtask

    task automatic read_check(input reg_code_t code);
        @(posedge clk);
        rd_sel <= code;
        @(negedge clk);
        check_reg(rd_data, model_read(code), $sformatf("rd_data for code %h", code));
    endtask

    task automatic dump_check(input byte_t addr);
        @(posedge clk);
        dmp_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        if (addr == `DUMP_RFP) begin
            check_bank(dmp_dout[1:0], m_rfp, "rfp");
        end
        check_byte(dmp_dout, model_dump(addr), $sformatf("dump at %h", addr));
    endtask

    // rfp_we over dec_rfp over inc_rfp
    task automatic pulse_rfp(input logic inc, input logic dec, input logic we,
                             input bank_ptr_t imm);
        @(posedge clk);
        inc_rfp <= inc;
        dec_rfp <= dec;
        rfp_we  <= we;
        rfp_imm <= imm;
        @(posedge clk);
        inc_rfp <= 1'b0;
        dec_rfp <= 1'b0;
        rfp_we  <= 1'b0;
        if (we) begin
            m_rfp = imm;
        end else if (dec) begin
            m_rfp = m_rfp - 2'd1;
        end else if (inc) begin
            m_rfp = m_rfp + 2'd1;
        end
    endtask

    task automatic mem_write(input mem_addr_t a, input byte_t d);
        @(posedge clk);
        host_we   <= 1'b1;
        host_addr <= a;
        host_din  <= d;
        @(posedge clk);
        host_we <= 1'b0;
        m_mem[a] = d;
    endtask

    task automatic check_memory();
        for (int a = 0; a < 2**`MEM_AW; a++) begin
            @(posedge clk);
            host_addr <= mem_addr_t'(a);
            @(posedge clk);
            @(negedge clk);
            check_byte(host_dout, m_mem[a], $sformatf("memory at %h", a));
        end
    endtask

    // XIX, XDE and BC of the current bank
    task automatic setup_move(input reg_data_t src, input reg_data_t dst, input count_t bc);
        write_reg(8'h80, ws_long, src);
        write_reg(8'he8, ws_long, dst);
        write_reg(8'he4, ws_word, {16'd0, bc});
    endtask

    task automatic run_move(input logic down, input logic rpt_mode, input logic [1:0] waits);
        reg_data_t src;
        reg_data_t dst;
        reg_data_t word;
        count_t    bc;
        int        n;
        int        cycles;
        src  = model_read(8'h80);
        dst  = model_read(8'he8);
        word = model_read(8'he4);
        bc   = word[15:0];
        n    = rpt_mode ? int'(bc) : 1;
        @(posedge clk);
        start    <= 1'b1;
        dir      <= down;
        rpt      <= rpt_mode;
        mem_wait <= waits;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b1) begin
            $display("busy did not rise one clock after start");
            stop_failed();
        end
        cycles = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > MOVE_LIMIT) begin
                $display("timeout: no done pulse within %0d cycles of start", MOVE_LIMIT);
                stop_failed();
            end
        end
        if (busy !== 1'b0) begin
            $display("busy still high in the cycle of the done pulse");
            stop_failed();
        end
        // each byte costs mem_wait + 4 cycles
        if (cycles != n * (int'(waits) + 4)) begin
            $display("[ERROR] %0d ns: move took %0d cycles, expected %0d", $time, cycles,
                     n * (int'(waits) + 4));
            stop_failed();
        end
        for (int i = 0; i < n; i++) begin
            m_mem[dst[`MEM_AW-1:0]] = m_mem[src[`MEM_AW-1:0]];
            src = down ? src - 32'd1 : src + 32'd1;
            dst = down ? dst - 32'd1 : dst + 32'd1;
            bc  = bc - 16'd1;
        end
        model_write(8'h80, ws_long, src);
        model_write(8'he8, ws_long, dst);
        model_write(8'he4, ws_word, {16'd0, bc});
        read_check(8'h80);
        read_check(8'he8);
        read_check(8'he4);
        check_memory();
    endtask

    initial begin
        logic [31:0] v;
        reg_code_t   code;
        reg_code_t   abs_code;
        wsize_e      size;
        reg_data_t   data;
        int          base;

        lfsr      = 16'd22;
        clk       = 1'b0;
        rst       = 1'b1;
        cen       = 1'b1;
        inc_rfp   = 1'b0;
        dec_rfp   = 1'b0;
        rfp_we    = 1'b0;
        rfp_imm   = '0;
        reg_we    = 1'b0;
        reg_sel   = '0;
        reg_size  = ws_byte;
        reg_din   = '0;
        rd_sel    = '0;
        dmp_addr  = '0;
        host_we   = 1'b0;
        host_addr = '0;
        host_din  = '0;
        start     = 1'b0;
        dir       = 1'b0;
        rpt       = 1'b0;
        mem_wait  = '0;
        m_rfp     = '0;
        for (int i = 0; i < 80; i++) begin
            m_regs[i] = 8'h00;
        end
        // XSP sits in pointer bytes 12..15
        for (int k = 0; k < 4; k++) begin
            m_regs[76 + k] = XSP_VALUE[8*k +: 8];
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // reset state of banks, pointers and rfp
        for (int a = 0; a <= 8'h50; a++) begin
            dump_check(byte_t'(a));
        end

        for (int i = 0; i < 40; i++) begin
            code = rand_abs_code();
            size = rand_size();
            data = rand_bits(32);
            write_reg(code, size, data);
            read_check(code);
            if (code[7:4] != 4'h4) begin
                base = model_index(code) & ~3;
                for (int k = 0; k < 4; k++) begin
                    dump_check(byte_t'(base + k));
                end
            end
            dump_check(byte_t'(rand_bits(8)));
        end

        // bank pointer strobes, then access through the relative codes
        for (int i = 0; i < 30; i++) begin
            v = rand_bits(7);
            pulse_rfp(v[0], v[1], v[2] & v[3], v[5:4]);
            dump_check(`DUMP_RFP);
            code     = {v[6] ? `CUR_BANK : `PREV_BANK, 4'(rand_bits(4))};
            abs_code = {2'b00, (code[7:4] == `CUR_BANK) ? m_rfp : m_rfp - 2'd1, code[3:0]};
            size     = rand_size();
            data     = rand_bits(32);
            write_reg(code, size, data);
            read_check(code);
            read_check(abs_code);
        end

        for (int a = 0; a < 2**`MEM_AW; a++) begin
            mem_write(mem_addr_t'(a), byte_t'(rand_bits(8)));
        end

        // one byte up, then one byte down
        for (int i = 0; i < 2; i++) begin
            setup_move(rand_bits(32), rand_bits(32), count_t'(rand_bits(8)) + 16'd1);
            run_move(i[0], 1'b0, 2'(rand_bits(2)));
        end

        for (int i = 0; i < 8; i++) begin
            v = rand_bits(8);
            pulse_rfp(1'b0, 1'b0, 1'b1, v[1:0]);
            setup_move(rand_bits(32), rand_bits(32), {13'd0, v[4:2]} + 16'd1);
            run_move(v[5], 1'b1, v[7:6]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
cpu_pkg.sv
reg_bank.sv
xfer_ctrl.sv
wait_timer.sv
byte_ram.sv
xfer_top.sv
tb_xfer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_xfer
LINT_TOP  ?= xfer_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -j 0 $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR)
